/* issue_pkg.sv */
package issue_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt
    } alu_op_e;

    typedef enum logic {
        exe_alu,
        exe_branch
    } exe_type_e;

    typedef enum logic {
        br_eq,
        br_ne
    } branch_type_e;

    // one decoded instruction as it waits in the queue
    typedef struct packed {
        alu_op_e                 alu_op;
        exe_type_e               exe_type;
        branch_type_e            branch_type;
        logic                    num1_need;       // low selects the immediate in num1
        logic [REG_ADDR_W-1:0]   num1_addr;
        logic [DATA_W-1:0]       num1;
        logic                    num2_need;
        logic [REG_ADDR_W-1:0]   num2_addr;
        logic [DATA_W-1:0]       num2;
        logic                    write_reg_need;
        logic [REG_ADDR_W-1:0]   write_reg_addr;
        logic [DATA_W-1:0]       branch_target;
    } iq_entry_t;

    typedef struct packed {
        logic [1:0] position;  // one-hot, bit 0 = lane stage 1, bit 1 = lane stage 2
        logic       lane;
    } sb_entry_t;

    typedef struct packed {
        logic                    valid;
        logic [DATA_W-1:0]       num1;
        logic [DATA_W-1:0]       num2;
        alu_op_e                 alu_op;
        exe_type_e               exe_type;
        branch_type_e            branch_type;
        logic                    write_reg_need;
        logic [REG_ADDR_W-1:0]   write_reg_addr;
        logic [DATA_W-1:0]       branch_target;
    } fu_req_t;

    typedef struct packed {
        logic                    valid;
        logic [REG_ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic                    valid;
        logic                    taken;
        logic [DATA_W-1:0]       target;
    } branch_res_t;

endpackage

/* inst_queue.sv */
`timescale 1ns/10ps

module inst_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  issue_pkg::iq_entry_t        in_entry,
    input  logic                        in_valid,
    output logic                        in_ready,
    output issue_pkg::iq_entry_t [1:0]  head,
    output logic [1:0]                  iq_size,
    input  logic [1:0]                  iq_pop_number
);
    localparam int PTR_W = $clog2(IQ_DEPTH);
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);

    issue_pkg::iq_entry_t mem [IQ_DEPTH];
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W-1:0]     wr_ptr;
    logic [CNT_W-1:0]     count;
    logic                 push;

    // wraps for any depth, not only powers of two
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] p, input logic [1:0] n);
        logic [PTR_W:0] sum;
        sum = (PTR_W+1)'(p) + (PTR_W+1)'(n);
        if (sum >= (PTR_W+1)'(IQ_DEPTH)) begin
            sum = sum - (PTR_W+1)'(IQ_DEPTH);
        end
        return sum[PTR_W-1:0];
    endfunction

    assign in_ready = (count != CNT_W'(IQ_DEPTH));
    assign push     = in_valid && in_ready;
    assign iq_size  = (count >= CNT_W'(2)) ? 2'd2 : count[1:0];  // saturates at 2

    assign head[0] = mem[rd_ptr];
    assign head[1] = mem[ptr_add(rd_ptr, 2'd1)];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_add(wr_ptr, 2'd1);
            end
            rd_ptr <= ptr_add(rd_ptr, iq_pop_number);
            count  <= count + CNT_W'(push) - CNT_W'(iq_pop_number);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_entry;
        end
    end

    pop_le_size_a: assert property (@(posedge clk) disable iff (!rst_n)
        iq_pop_number <= iq_size)
        else $error("issue popped %0d entries with only %0d visible", iq_pop_number, iq_size);

endmodule

/* score_board.sv */
`timescale 1ns/10ps

module score_board (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [3:0][issue_pkg::REG_ADDR_W-1:0]   sb_addr,
    output issue_pkg::sb_entry_t [3:0]              sb_data,
    input  issue_pkg::fu_req_t [1:0]                fu_req
);
    issue_pkg::sb_entry_t [issue_pkg::NUM_REGS-1:0] sb_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sb_q <= '0;
        end else begin
            // producers move one stage down the lane
            for (int r = 0; r < issue_pkg::NUM_REGS; r++) begin
                sb_q[r].position <= {sb_q[r].position[0], 1'b0};
            end
            // lane 1 goes last so it overrides lane 0 on the same register
            for (int i = 0; i < 2; i++) begin
                if (fu_req[i].valid && fu_req[i].write_reg_need &&
                    fu_req[i].write_reg_addr != '0) begin
                    sb_q[fu_req[i].write_reg_addr].position <= 2'b01;
                    sb_q[fu_req[i].write_reg_addr].lane     <= 1'(i);
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            sb_data[k] = sb_q[sb_addr[k]];
        end
    end

endmodule

/* regfile.sv */
`timescale 1ns/10ps

module regfile (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [3:0][issue_pkg::REG_ADDR_W-1:0]   rd_addr,
    output logic [3:0][issue_pkg::DATA_W-1:0]       rd_data,
    input  issue_pkg::wb_t [1:0]                    wb
);
    logic [issue_pkg::DATA_W-1:0] regs [issue_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < issue_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin  // lane 1 last so it wins on same addr
                if (wb[i].valid && wb[i].addr != '0) begin
                    regs[wb[i].addr] <= wb[i].data;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rd_data[k] = regs[rd_addr[k]];  // r0 is never written so it reads zero
        end
    end

endmodule

/* issue.sv */
`timescale 1ns/10ps

module issue (
    input  issue_pkg::iq_entry_t [1:0]              head,
    input  logic [1:0]                              iq_size,
    output logic [1:0]                              iq_pop_number,
    output logic [3:0][issue_pkg::REG_ADDR_W-1:0]   sb_addr,
    input  issue_pkg::sb_entry_t [3:0]              sb_data,
    output logic [3:0][issue_pkg::REG_ADDR_W-1:0]   rd_addr,
    input  logic [3:0][issue_pkg::DATA_W-1:0]       rd_data,
    input  issue_pkg::wb_t [1:0]                    bypass,
    output issue_pkg::fu_req_t [1:0]                fu_req
);
    logic [3:0][issue_pkg::REG_ADDR_W-1:0] src_addr;
    logic [3:0]                            src_need;
    logic [3:0][issue_pkg::DATA_W-1:0]     src_imm;
    logic [3:0]                            src_ready;
    logic [3:0][issue_pkg::DATA_W-1:0]     src_val;
    logic [1:0]                            writes;
    logic                                  first_ready;
    logic                                  second_ready;
    logic                                  dep;
    logic                                  second_ok;

    // operand slots in order head0 num1, head0 num2, head1 num1, head1 num2
    assign src_addr = {head[1].num2_addr, head[1].num1_addr,
                       head[0].num2_addr, head[0].num1_addr};
    assign src_need = {head[1].num2_need, head[1].num1_need,
                       head[0].num2_need, head[0].num1_need};
    assign src_imm  = {head[1].num2, head[1].num1, head[0].num2, head[0].num1};

    assign sb_addr = src_addr;
    assign rd_addr = src_addr;

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (!src_need[k]) begin
                src_ready[k] = 1'b1;  // imm
                src_val[k]   = src_imm[k];
            end else if (sb_data[k].position == 2'b00) begin
                src_ready[k] = 1'b1;
                src_val[k]   = rd_data[k];
            end else if (sb_data[k].position == 2'b10) begin
                src_ready[k] = 1'b1;  // producer sits in stage 2
                src_val[k]   = bypass[sb_data[k].lane].data;
            end else begin
                src_ready[k] = 1'b0;
                src_val[k]   = '0;
            end
        end
    end

    // branches never write a register
    assign writes[0] = head[0].write_reg_need && head[0].exe_type == issue_pkg::exe_alu;
    assign writes[1] = head[1].write_reg_need && head[1].exe_type == issue_pkg::exe_alu;

    assign first_ready  = &src_ready[1:0];
    assign second_ready = &src_ready[3:2];

    // no in-pair bypass so a reader of head0's result waits a cycle
    assign dep = writes[0] &&
                 ((src_need[2] && src_addr[2] == head[0].write_reg_addr) ||
                  (src_need[3] && src_addr[3] == head[0].write_reg_addr));
    assign second_ok = (iq_size == 2'd2) && second_ready && !dep;

    always_comb begin
        if (iq_size == 2'd0 || !first_ready) begin
            iq_pop_number = 2'd0;
        end else if (head[0].exe_type == issue_pkg::exe_branch) begin
            iq_pop_number = second_ok ? 2'd2 : 2'd0;  // branch leaves with its delay slot
        end else if (!second_ok || head[1].exe_type == issue_pkg::exe_branch) begin
            iq_pop_number = 2'd1;
        end else begin
            iq_pop_number = 2'd2;
        end
    end

    function automatic issue_pkg::fu_req_t make_req(
        input issue_pkg::iq_entry_t         e,
        input logic                         v,
        input logic                         w,
        input logic [issue_pkg::DATA_W-1:0] a,
        input logic [issue_pkg::DATA_W-1:0] b
    );
        issue_pkg::fu_req_t r;
        r.valid          = v;
        r.num1           = a;
        r.num2           = b;
        r.alu_op         = e.alu_op;
        r.exe_type       = e.exe_type;
        r.branch_type    = e.branch_type;
        r.write_reg_need = w;
        r.write_reg_addr = e.write_reg_addr;
        r.branch_target  = e.branch_target;
        return r;
    endfunction

    assign fu_req[0] = make_req(head[0], iq_pop_number != 2'd0, writes[0], src_val[0], src_val[1]);
    assign fu_req[1] = make_req(head[1], iq_pop_number == 2'd2, writes[1], src_val[2], src_val[3]);

    // a stage 2 producer must be on its lane's bypass port
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (src_need[k] && sb_data[k].position == 2'b10) begin
                assert final (bypass[sb_data[k].lane].valid &&
                              bypass[sb_data[k].lane].addr == src_addr[k])
                    else $error("operand %0d finds no bypass result for r%0d",
                                k, src_addr[k]);
            end
        end
    end

endmodule

/* exec_lane.sv */
`timescale 1ns/10ps

module exec_lane (
    input  logic                    clk,
    input  logic                    rst_n,
    input  issue_pkg::fu_req_t      fu_req,
    output issue_pkg::wb_t          wb,
    output issue_pkg::branch_res_t  br_res
);
    issue_pkg::fu_req_t             s1_req;
    logic [issue_pkg::DATA_W-1:0]   alu_res;
    logic                           br_taken;

    // stage 1 holds the request
    always_ff @(posedge clk) begin
        s1_req <= fu_req;
        if (!rst_n) begin
            s1_req.valid <= 1'b0;
        end
    end

    always_comb begin
        case (s1_req.alu_op)
            issue_pkg::op_add: alu_res = s1_req.num1 + s1_req.num2;
            issue_pkg::op_sub: alu_res = s1_req.num1 - s1_req.num2;
            issue_pkg::op_and: alu_res = s1_req.num1 & s1_req.num2;
            issue_pkg::op_or:  alu_res = s1_req.num1 | s1_req.num2;
            issue_pkg::op_xor: alu_res = s1_req.num1 ^ s1_req.num2;
            issue_pkg::op_slt: alu_res = {{(issue_pkg::DATA_W-1){1'b0}},
                                          $signed(s1_req.num1) < $signed(s1_req.num2)};
            default:           alu_res = '0;
        endcase
    end

    assign br_taken = (s1_req.branch_type == issue_pkg::br_eq) ?
                      (s1_req.num1 == s1_req.num2) : (s1_req.num1 != s1_req.num2);

    // stage 2 drives bypass, writeback and branch outcome
    always_ff @(posedge clk) begin
        wb.valid      <= s1_req.valid && s1_req.write_reg_need;
        wb.addr       <= s1_req.write_reg_addr;
        wb.data       <= alu_res;
        br_res.valid  <= s1_req.valid && s1_req.exe_type == issue_pkg::exe_branch;
        br_res.taken  <= br_taken;
        br_res.target <= s1_req.branch_target;
        if (!rst_n) begin
            wb.valid     <= 1'b0;
            br_res.valid <= 1'b0;
        end
    end

    wb_br_exclusive_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(wb.valid && br_res.valid))
        else $error("lane reports writeback and branch together");

endmodule

/* issue_core_top.sv */
`timescale 1ns/10ps

module issue_core_top #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  issue_pkg::iq_entry_t            in_entry,
    input  logic                            in_valid,
    output logic                            in_ready,
    output issue_pkg::wb_t [1:0]            wb,
    output issue_pkg::branch_res_t [1:0]    br_res
);
    issue_pkg::iq_entry_t [1:0]             head;
    logic [1:0]                             iq_size;
    logic [1:0]                             iq_pop_number;
    logic [3:0][issue_pkg::REG_ADDR_W-1:0]  sb_addr;
    issue_pkg::sb_entry_t [3:0]             sb_data;
    logic [3:0][issue_pkg::REG_ADDR_W-1:0]  rd_addr;
    logic [3:0][issue_pkg::DATA_W-1:0]      rd_data;
    issue_pkg::fu_req_t [1:0]               fu_req;

    inst_queue #(
        .IQ_DEPTH(IQ_DEPTH)
    ) u_inst_queue (
        .clk(clk),
        .rst_n(rst_n),
        .in_entry(in_entry),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .head(head),
        .iq_size(iq_size),
        .iq_pop_number(iq_pop_number)
    );

    score_board u_score_board (
        .clk(clk),
        .rst_n(rst_n),
        .sb_addr(sb_addr),
        .sb_data(sb_data),
        .fu_req(fu_req)
    );

    regfile u_regfile (
        .clk(clk),
        .rst_n(rst_n),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .wb(wb)
    );

    issue u_issue (
        .head(head),
        .iq_size(iq_size),
        .iq_pop_number(iq_pop_number),
        .sb_addr(sb_addr),
        .sb_data(sb_data),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .bypass(wb),
        .fu_req(fu_req)
    );

    exec_lane u_lane0 (
        .clk(clk),
        .rst_n(rst_n),
        .fu_req(fu_req[0]),  // always the older instruction
        .wb(wb[0]),
        .br_res(br_res[0])
    );

    exec_lane u_lane1 (
        .clk(clk),
        .rst_n(rst_n),
        .fu_req(fu_req[1]),
        .wb(wb[1]),
        .br_res(br_res[1])
    );

endmodule

/* tb_issue_core.sv */
`timescale 1ns/10ps

module tb_issue_core;

    localparam int IQ_DEPTH   = 8;
    localparam int WAIT_LIMIT = 200;

    logic                           clk;
    logic                           rst_n;
    issue_pkg::iq_entry_t           in_entry;
    logic                           in_valid;
    logic                           in_ready;
    issue_pkg::wb_t [1:0]           wb;
    issue_pkg::branch_res_t [1:0]   br_res;

    logic [31:0] seed;
    logic [31:0] model_regs [issue_pkg::NUM_REGS];
    logic [4:0]  last_dest;
    logic        slot_due;      // previous instruction was a branch
    logic        hung;
    logic [4:0]  exp_wb_addr [$];
    logic [31:0] exp_wb_data [$];
    logic        exp_br_taken [$];
    logic [31:0] exp_br_target [$];
    int          check_errors;
    int          timeouts;
    int          dual_wb_cycles;
    int          stall_cycles;
    int          waited;

    issue_core_top #(
        .IQ_DEPTH(IQ_DEPTH)
    ) uut (
        .clk(clk),
        .rst_n(rst_n),
        .in_entry(in_entry),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .wb(wb),
        .br_res(br_res)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        seed = xorshift(seed);
        return seed;
    endfunction

    // expected ALU result from the opcode definitions
    function automatic logic [31:0] alu_ref(input issue_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            issue_pkg::op_add: return a + b;
            issue_pkg::op_sub: return a - b;
            issue_pkg::op_and: return a & b;
            issue_pkg::op_or:  return a | b;
            issue_pkg::op_xor: return a ^ b;
            issue_pkg::op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:           return 32'd0;
        endcase
    endfunction

    // mode 0 independent, 1 chain, 2 branch heavy, 3 dense mix
    task automatic build_inst(input int mode, output issue_pkg::iq_entry_t e);
        logic [31:0] r;
        logic        make_branch;
        r = next_rand();
        e = '0;
        make_branch = 1'b0;
        e.alu_op         = issue_pkg::alu_op_e'(r[2:0] % 3'd6);
        e.branch_type    = r[3] ? issue_pkg::br_ne : issue_pkg::br_eq;
        e.num1           = r[4] ? {29'd0, r[7:5]} : next_rand();  // small values hit equal compares
        e.num2           = r[8] ? {29'd0, r[11:9]} : next_rand();
        e.num1_addr      = {3'd0, r[13:12]};
        e.num2_addr      = {3'd0, r[15:14]};
        e.write_reg_addr = {3'd0, r[17:16]} + 5'd1;  // r1..r4
        if (mode == 1) begin
            e.num1_need = 1'b1;
            e.num1_addr = last_dest;
            e.num2_need = r[18];
        end else if (mode == 2) begin
            e.num1_need = 1'b1;
            e.num2_need = 1'b1;
            make_branch = !slot_due && r[24];
        end else if (mode == 3) begin
            e.num1_need = r[19] | r[20];
            e.num2_need = r[21] | r[22];
            make_branch = !slot_due && (r[25:24] == 2'b00);
        end
        if (make_branch) begin
            e.exe_type      = issue_pkg::exe_branch;
            e.branch_target = next_rand();
        end else begin
            e.exe_type       = issue_pkg::exe_alu;
            e.write_reg_need = 1'b1;
            last_dest        = e.write_reg_addr;
        end
        slot_due = make_branch;
    endtask

    // runs one accepted instruction in program order on the model
    task automatic model_apply(input issue_pkg::iq_entry_t e);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = e.num1_need ? model_regs[e.num1_addr] : e.num1;
        b = e.num2_need ? model_regs[e.num2_addr] : e.num2;
        if (e.exe_type == issue_pkg::exe_branch) begin
            exp_br_taken.push_back((e.branch_type == issue_pkg::br_eq) ? (a == b) : (a != b));
            exp_br_target.push_back(e.branch_target);
        end else begin
            res = alu_ref(e.alu_op, a, b);
            exp_wb_addr.push_back(e.write_reg_addr);
            exp_wb_data.push_back(res);
            if (e.write_reg_addr != 5'd0) begin
                model_regs[e.write_reg_addr] = res;
            end
        end
    endtask

    // called on a rising edge and returns on the edge that takes the entry
    task automatic send_inst(input issue_pkg::iq_entry_t e);
        int  n;
        logic done;
        in_entry <= e;
        in_valid <= 1'b1;
        n = 0;
        done = 1'b0;
        while (!done && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            done = in_ready;
        end
        if (done) begin
            model_apply(e);
        end else begin
            $display("input handshake timed out after %0d cycles", WAIT_LIMIT);
            timeouts++;
            hung = 1'b1;
        end
    endtask

    task automatic run_phase(input int mode, input int count);
        issue_pkg::iq_entry_t e;
        for (int i = 0; i < count; i++) begin
            if (!hung) begin
                build_inst(mode, e);
                send_inst(e);
            end
        end
    endtask

    task automatic check_lane(input logic lane);
        logic [4:0]  addr;
        logic [31:0] data;
        logic        taken;
        if (wb[lane].valid) begin
            assert (exp_wb_addr.size() != 0) else begin
                $display("lane %0d wrote r%0d at %0t with no writeback expected",
                         lane, wb[lane].addr, $time);
                check_errors++;
            end
            if (exp_wb_addr.size() != 0) begin
                addr = exp_wb_addr.pop_front();
                data = exp_wb_data.pop_front();
                assert (wb[lane].addr == addr) else begin
                    $display("CHECK FAILED t=%0t wb[%0d].addr got %0d expected %0d",
                             $time, lane, wb[lane].addr, addr);
                    check_errors++;
                end
                assert (wb[lane].data == data) else begin
                    $display("CHECK FAILED t=%0t wb[%0d].data got %h expected %h",
                             $time, lane, wb[lane].data, data);
                    check_errors++;
                end
            end
        end
        if (br_res[lane].valid) begin
            assert (exp_br_taken.size() != 0) else begin
                $display("lane %0d reported a branch at %0t with none expected", lane, $time);
                check_errors++;
            end
            if (exp_br_taken.size() != 0) begin
                taken = exp_br_taken.pop_front();
                data  = exp_br_target.pop_front();
                assert (br_res[lane].taken == taken) else begin
                    $display("CHECK FAILED t=%0t br_res[%0d].taken got %0b expected %0b",
                             $time, lane, br_res[lane].taken, taken);
                    check_errors++;
                end
                assert (br_res[lane].target == data) else begin
                    $display("CHECK FAILED t=%0t br_res[%0d].target got %h expected %h",
                             $time, lane, br_res[lane].target, data);
                    check_errors++;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (in_valid && !in_ready) begin
                stall_cycles++;
            end
            if (wb[0].valid && wb[1].valid) begin
                dual_wb_cycles++;
            end
            check_lane(1'b0);  // older instruction first
            check_lane(1'b1);
        end
    end

    initial begin
        rst_n          <= 1'b0;
        in_valid       <= 1'b0;
        in_entry       <= '0;
        seed           = 32'h02d1_bd9f;
        last_dest      = 5'd1;
        slot_due       = 1'b0;
        hung           = 1'b0;
        check_errors   = 0;
        timeouts       = 0;
        dual_wb_cycles = 0;
        stall_cycles   = 0;
        for (int r = 0; r < issue_pkg::NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!wb[0].valid && !wb[1].valid && !br_res[0].valid && !br_res[1].valid) else begin
            $display("CHECK FAILED t=%0t wb/br_res valid got %b%b%b%b expected 0000", $time,
                     wb[0].valid, wb[1].valid, br_res[0].valid, br_res[1].valid);
            check_errors++;
        end
        assert (in_ready) else begin
            $display("CHECK FAILED t=%0t in_ready got %0b expected 1", $time, in_ready);
            check_errors++;
        end
        run_phase(1, 16);   // chain stalls issue and fills the queue
        run_phase(0, 16);   // backlog of independent ops pairs up
        run_phase(2, 24);
        run_phase(3, 160);
        if (slot_due) begin
            run_phase(0, 1);  // last branch needs its delay slot
        end
        in_valid <= 1'b0;
        waited = 0;
        while (!hung && (exp_wb_addr.size() != 0 || exp_br_taken.size() != 0) &&
               waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!hung && (exp_wb_addr.size() != 0 || exp_br_taken.size() != 0)) begin
            $display("drain timed out with %0d writebacks and %0d branches missing",
                     exp_wb_addr.size(), exp_br_taken.size());
            timeouts++;
        end
        repeat (4) @(posedge clk);  // catch stray results
        @(negedge clk);
        assert (dual_wb_cycles > 0) else begin
            $display("two writebacks never appeared in the same cycle");
            check_errors++;
        end
        assert (stall_cycles > 0) else begin
            $display("in_ready never dropped while input was held valid");
            check_errors++;
        end
        $display("errors: %0d check, %0d timeout", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* filelist.f */
issue_pkg.sv
inst_queue.sv
score_board.sv
regfile.sv
issue.sv
exec_lane.sv
issue_core_top.sv
tb_issue_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_issue_core -f filelist.f -o sim_issue_core
./obj_dir/sim_issue_core | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    exit 0
fi
exit 1
